// File: include/adc_slice_settings.svh
`ifndef ADC_SLICE_SETTINGS_SVH
`define ADC_SLICE_SETTINGS_SVH

// divider counter width
`define SLICE_NDIV 2
// magnitude width of the quantizer output
`define SLICE_NADC 8
// signed input code width, wider than SLICE_NADC + 1
`define SLICE_NIN 12

// derived values
`define SLICE_SHIFT (`SLICE_NIN - `SLICE_NADC - 1)
`define SLICE_MAG_MAX {`SLICE_NADC{1'b1}}

`endif

// File: rtl/adc_slice_pkg.sv
package adc_slice_pkg;

    // decoded operating state of the slice
    typedef enum logic [1:0] {
        st_idle,
        st_armed,
        st_run,
        st_forced
    } slice_state_t;

    // operation the divider counter performs on the next emu_clk edge
    typedef enum logic [1:0] {
        cnt_hold,
        cnt_load,
        cnt_force,
        cnt_step
    } count_op_t;

endpackage

// File: rtl/slice_sync_fsm.sv
`timescale 1ns/10ps

module slice_sync_fsm (
    input  logic                     emu_clk,
    input  logic                     rstb,
    input  logic                     clk_in,
    input  logic                     en_slice,
    input  logic                     en_sync_in,
    input  logic                     alws_on,
    output logic                     en_sync_out,
    output adc_slice_pkg::count_op_t count_op
);
    import adc_slice_pkg::*;

    logic         clk_in_d;
    logic         rise_seen;
    logic         fall_seen;
    logic         en_sampled;
    slice_state_t state;

    //////////////////////////////////////////////////////////////////////
    // clk_in edge detection
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge emu_clk or negedge rstb) begin
        if (!rstb) begin
            clk_in_d <= 1'b0;
        end else begin
            clk_in_d <= clk_in;
        end
    end

    assign rise_seen = clk_in & ~clk_in_d;
    assign fall_seen = ~clk_in & clk_in_d;

    //////////////////////////////////////////////////////////////////////
    // enable synchronizer
    //////////////////////////////////////////////////////////////////////

    // enable is sampled on falling clk_in edges
    always_ff @(posedge emu_clk or negedge rstb) begin
        if (!rstb) begin
            en_sampled <= 1'b0;
        end else if (fall_seen) begin
            en_sampled <= en_sync_in;
        end
    end

    // and forwarded on the following rising edge
    always_ff @(posedge emu_clk or negedge rstb) begin
        if (!rstb) begin
            en_sync_out <= 1'b0;
        end else if (rise_seen) begin
            en_sync_out <= en_sampled;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // slice state and counter opcode
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        if (!en_slice) begin
            state = st_idle;
        end else if (!en_sampled) begin
            state = st_armed;
        end else if (alws_on) begin
            state = st_forced;
        end else begin
            state = st_run;
        end
    end

    // counter stays loaded with init until the slice is synchronized
    always_comb begin
        case (state)
            st_idle:   count_op = cnt_load;
            st_armed:  count_op = cnt_load;
            st_forced: count_op = cnt_force;
            default:   count_op = fall_seen ? cnt_step : cnt_hold;
        endcase
    end

    // a step only happens while running, in the cycle after clk_in fell
    a_step_only_in_run: assert property (
        @(posedge emu_clk) disable iff (!rstb)
        (count_op == cnt_step) |-> (state == st_run && !clk_in && $past(clk_in))
    ) else $error("slice_sync_fsm: cnt_step outside a running falling edge");

endmodule

// File: rtl/phase_counter.sv
`timescale 1ns/10ps

`include "adc_slice_settings.svh"

module phase_counter (
    input  logic                     emu_clk,
    input  logic                     rstb,
    input  adc_slice_pkg::count_op_t count_op,
    input  logic [`SLICE_NDIV-1:0]   init,
    output logic                     clk_adder
);
    import adc_slice_pkg::*;

    localparam int NDIV = `SLICE_NDIV;

    logic [NDIV-1:0] count;

    //////////////////////////////////////////////////////////////////////
    // divider count
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge emu_clk or negedge rstb) begin
        if (!rstb) begin
            count <= '0;
        end else begin
            case (count_op)
                cnt_load: begin
                    count <= init;
                end
                cnt_force: begin
                    count <= {NDIV{1'b1}};
                end
                cnt_step: begin
                    // wraps at the top of the range
                    count <= count + 1'b1;
                end
                default: begin
                    count <= count;
                end
            endcase
        end
    end

    // adder clock is high for the lower half of the count range
    assign clk_adder = ~count[NDIV-1];

    // forced count sits at all ones, which keeps clk_adder low
    a_force_all_ones: assert property (
        @(posedge emu_clk) disable iff (!rstb)
        (count_op == cnt_force) |=> (count == {NDIV{1'b1}})
    ) else $error("phase_counter: count not all ones after cnt_force");

endmodule

// File: rtl/sign_mag_quantizer.sv
`timescale 1ns/10ps

`include "adc_slice_settings.svh"

module sign_mag_quantizer (
    input  logic                         emu_clk,
    input  logic                         rstb,
    input  logic                         clk_adder,
    input  logic signed [`SLICE_NIN-1:0] vin_code,
    output logic                         sign_out,
    output logic [`SLICE_NADC-1:0]       adder_out
);
    localparam int NIN   = `SLICE_NIN;
    localparam int NADC  = `SLICE_NADC;
    localparam int SHIFT = `SLICE_SHIFT;

    localparam logic [NADC-1:0] MAG_MAX   = `SLICE_MAG_MAX;
    localparam logic [NIN-1:0]  SAT_LIMIT = NIN'(MAG_MAX);

    logic                  clk_adder_d;
    logic                  adder_rise;
    logic                  cap_valid;
    logic signed [NIN-1:0] vin_cap;
    logic [NIN-1:0]        abs_code;
    logic [NIN-1:0]        shifted;
    logic [NADC-1:0]       mag_next;

    //////////////////////////////////////////////////////////////////////
    // adder clock edge and input capture
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge emu_clk or negedge rstb) begin
        if (!rstb) begin
            clk_adder_d <= 1'b0;
            cap_valid   <= 1'b0;
        end else begin
            clk_adder_d <= clk_adder;
            cap_valid   <= adder_rise;
        end
    end

    assign adder_rise = clk_adder & ~clk_adder_d;

    always_ff @(posedge emu_clk) begin
        if (adder_rise) begin
            vin_cap <= vin_code;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // sign and saturated magnitude
    //////////////////////////////////////////////////////////////////////

    // most negative code becomes 2**(NIN-1) when read unsigned
    assign abs_code = vin_cap[NIN-1] ? (~vin_cap + 1'b1) : vin_cap;
    assign shifted  = abs_code >> SHIFT;
    assign mag_next = (shifted > SAT_LIMIT) ? MAG_MAX : shifted[NADC-1:0];

    always_ff @(posedge emu_clk or negedge rstb) begin
        if (!rstb) begin
            sign_out  <= 1'b0;
            adder_out <= '0;
        end else if (cap_valid) begin
            sign_out  <= vin_cap[NIN-1];
            adder_out <= mag_next;
        end
    end

    // out of range codes land on the full scale magnitude
    a_saturate: assert property (
        @(posedge emu_clk) disable iff (!rstb)
        (cap_valid && shifted > SAT_LIMIT) |=> (adder_out == MAG_MAX)
    ) else $error("sign_mag_quantizer: magnitude above full scale not saturated");

endmodule

// File: rtl/adc_slice_top.sv
`timescale 1ns/10ps

`include "adc_slice_settings.svh"

module adc_slice_top (
    input  logic                         emu_clk,
    input  logic                         rstb,
    input  logic                         clk_in,
    input  logic                         en_slice,
    input  logic                         en_sync_in,
    input  logic                         alws_on,
    input  logic [`SLICE_NDIV-1:0]       init,
    input  logic signed [`SLICE_NIN-1:0] vin_code,
    output logic                         en_sync_out,
    output logic                         clk_adder,
    output logic                         sign_out,
    output logic [`SLICE_NADC-1:0]       adder_out
);
    import adc_slice_pkg::*;

    count_op_t count_op;

    //////////////////////////////////////////////////////////////////////
    // enable sync and slice control
    //////////////////////////////////////////////////////////////////////

    slice_sync_fsm u_sync_fsm (
        .emu_clk     (emu_clk),
        .rstb        (rstb),
        .clk_in      (clk_in),
        .en_slice    (en_slice),
        .en_sync_in  (en_sync_in),
        .alws_on     (alws_on),
        .en_sync_out (en_sync_out),
        .count_op    (count_op)
    );

    //////////////////////////////////////////////////////////////////////
    // clock divider
    //////////////////////////////////////////////////////////////////////

    phase_counter u_phase_counter (
        .emu_clk   (emu_clk),
        .rstb      (rstb),
        .count_op  (count_op),
        .init      (init),
        .clk_adder (clk_adder)
    );

    //////////////////////////////////////////////////////////////////////
    // quantizer
    //////////////////////////////////////////////////////////////////////

    // samples on the divided adder clock
    sign_mag_quantizer u_quantizer (
        .emu_clk   (emu_clk),
        .rstb      (rstb),
        .clk_adder (clk_adder),
        .vin_code  (vin_code),
        .sign_out  (sign_out),
        .adder_out (adder_out)
    );

endmodule

// File: bench/adc_slice_tb.sv
`timescale 1ns/10ps

`include "adc_slice_settings.svh"

module adc_slice_tb;

    localparam int NDIV    = `SLICE_NDIV;
    localparam int NADC    = `SLICE_NADC;
    localparam int NIN     = `SLICE_NIN;
    localparam int SHIFT   = NIN - NADC - 1;
    localparam int MAG_TOP = (1 << NADC) - 1;

    // cycles per test phase
    localparam int RESET_CYCLES = 20;
    localparam int SYNC_CYCLES  = 400;
    localparam int DIV_CYCLES   = 500;
    localparam int ALWS_CYCLES  = 300;
    localparam int QUANT_CYCLES = 800;
    localparam int TOTAL_CYCLES = 2 + RESET_CYCLES + SYNC_CYCLES + DIV_CYCLES
                                  + ALWS_CYCLES + QUANT_CYCLES;
    localparam int CLK_PERIOD   = 8;

    logic                  emu_clk;
    logic                  rstb;
    logic                  clk_in;
    logic                  en_slice;
    logic                  en_sync_in;
    logic                  alws_on;
    logic [NDIV-1:0]       init;
    logic signed [NIN-1:0] vin_code;
    logic                  en_sync_out;
    logic                  clk_adder;
    logic                  sign_out;
    logic [NADC-1:0]       adder_out;

    // values applied on the next rising edge
    logic                  nxt_en_slice;
    logic                  nxt_en_sync_in;
    logic                  nxt_alws_on;
    logic [NDIV-1:0]       nxt_init;
    logic signed [NIN-1:0] nxt_vin_code;
    logic                  clk_level;
    int                    hold_left;
    int                    seed;

    // cycle model registers
    logic                  m_clk_in_d;
    logic                  m_en_sampled;
    logic                  m_en_sync_out;
    logic [NDIV-1:0]       m_count;
    logic                  m_clk_adder_d;
    logic                  m_cap_valid;
    logic signed [NIN-1:0] m_vin_cap;
    logic                  m_sign;
    logic [NADC-1:0]       m_mag;

    string cur_test;
    int    test_errors;
    int    total_errors;
    int    tests_run;
    int    tests_failed;
    int    low_cycles;

    adc_slice_top dut (
        .emu_clk     (emu_clk),
        .rstb        (rstb),
        .clk_in      (clk_in),
        .en_slice    (en_slice),
        .en_sync_in  (en_sync_in),
        .alws_on     (alws_on),
        .init        (init),
        .vin_code    (vin_code),
        .en_sync_out (en_sync_out),
        .clk_adder   (clk_adder),
        .sign_out    (sign_out),
        .adder_out   (adder_out)
    );

    initial begin
        emu_clk = 1'b0;
        forever #(CLK_PERIOD / 2) emu_clk = ~emu_clk;
    end

    initial begin : watchdog
        #((TOTAL_CYCLES + 100) * CLK_PERIOD);
        $display("run timed out before all test phases completed");
        $display("test failed");
        $finish;
    end

    function automatic int rand_below(input int n);
        return ($random(seed) & 32'h7fff_ffff) % n;
    endfunction

    // sign magnitude rule: |code| / 2**SHIFT, clipped at full scale
    function automatic logic [NADC-1:0] expected_mag(input logic signed [NIN-1:0] code);
        int mag;
        mag = int'(code);
        if (mag < 0) begin
            mag = -mag;
        end
        mag = mag / (1 << SHIFT);
        if (mag > MAG_TOP) begin
            mag = MAG_TOP;
        end
        return mag[NADC-1:0];
    endfunction

    //////////////////////////////////////////////////////////////////////
    // cycle model, sees the inputs from before this edge
    //////////////////////////////////////////////////////////////////////

    always @(posedge emu_clk) begin : cycle_model
        logic rise;
        logic fall;
        logic adder_now;
        logic adder_rise;
        if (!rstb) begin
            m_clk_in_d    = 1'b0;
            m_en_sampled  = 1'b0;
            m_en_sync_out = 1'b0;
            m_count       = '0;
            m_clk_adder_d = 1'b0;
            m_cap_valid   = 1'b0;
            m_vin_cap     = '0;
            m_sign        = 1'b0;
            m_mag         = '0;
        end else begin
            rise       = clk_in && !m_clk_in_d;
            fall       = !clk_in && m_clk_in_d;
            adder_now  = !m_count[NDIV-1];
            adder_rise = adder_now && !m_clk_adder_d;
            if (m_cap_valid) begin
                m_sign = (m_vin_cap < 0);
                m_mag  = expected_mag(m_vin_cap);
            end
            m_cap_valid = adder_rise;
            if (adder_rise) begin
                m_vin_cap = vin_code;
            end
            m_clk_adder_d = adder_now;
            if (!en_slice || !m_en_sampled) begin
                m_count = init;
            end else if (alws_on) begin
                m_count = '1;
            end else if (fall) begin
                m_count = NDIV'(m_count + 1);
            end
            if (rise) begin
                m_en_sync_out = m_en_sampled;
            end
            if (fall) begin
                m_en_sampled = en_sync_in;
            end
            m_clk_in_d = clk_in;
        end
    end

    task automatic check_value(input string sig, input logic [15:0] exp_v,
                               input logic [15:0] act_v);
        if (exp_v !== act_v) begin
            $display("Fail %s %s: expected %0h, actual %0h at %0t",
                     cur_test, sig, exp_v, act_v, $time);
            test_errors++;
        end
    endtask

    // one emu_clk cycle: drive on the rising edge, compare on the falling edge
    task automatic run_cycle();
        @(posedge emu_clk);
        if (hold_left == 0) begin
            clk_level = !clk_level;
            hold_left = 2 + rand_below(5);
        end
        hold_left--;
        clk_in     <= clk_level;
        en_slice   <= nxt_en_slice;
        en_sync_in <= nxt_en_sync_in;
        alws_on    <= nxt_alws_on;
        init       <= nxt_init;
        vin_code   <= nxt_vin_code;
        @(negedge emu_clk);
        check_value("en_sync_out", 16'(m_en_sync_out), 16'(en_sync_out));
        check_value("clk_adder", 16'(!m_count[NDIV-1]), 16'(clk_adder));
        check_value("sign_out", 16'(m_sign), 16'(sign_out));
        check_value("adder_out", 16'(m_mag), 16'(adder_out));
        if (!clk_adder) begin
            low_cycles++;
        end
    endtask

    task automatic begin_test(input string name);
        cur_test    = name;
        test_errors = 0;
        low_cycles  = 0;
    endtask

    task automatic end_test();
        tests_run++;
        total_errors += test_errors;
        if (test_errors > 0) begin
            tests_failed++;
        end
        $display("%-8s done, %0d errors", cur_test, test_errors);
    endtask

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin : main_flow
        seed           = 32'h8d9f;
        rstb           = 1'b0;
        clk_in         = 1'b0;
        en_slice       = 1'b0;
        en_sync_in     = 1'b0;
        alws_on        = 1'b0;
        init           = '0;
        vin_code       = '0;
        nxt_en_slice   = 1'b0;
        nxt_en_sync_in = 1'b0;
        nxt_alws_on    = 1'b0;
        nxt_init       = '0;
        nxt_vin_code   = '0;
        clk_level      = 1'b0;
        hold_left      = 3;
        tests_run      = 0;
        tests_failed   = 0;
        total_errors   = 0;
        repeat (2) @(posedge emu_clk);
        rstb <= 1'b1;

        begin_test("reset");
        @(negedge emu_clk);
        check_value("en_sync_out", 16'd0, 16'(en_sync_out));
        check_value("sign_out", 16'd0, 16'(sign_out));
        check_value("adder_out", 16'd0, 16'(adder_out));
        check_value("clk_adder", 16'd1, 16'(clk_adder));
        repeat (RESET_CYCLES) begin
            nxt_init = NDIV'(rand_below(1 << NDIV));
            run_cycle();
        end
        end_test();

        begin_test("sync");
        nxt_en_slice = 1'b1;
        repeat (SYNC_CYCLES) begin
            if (rand_below(8) == 0) begin
                nxt_en_sync_in = !nxt_en_sync_in;
            end
            nxt_vin_code = NIN'($random(seed));
            run_cycle();
        end
        end_test();

        // mostly synchronized, with an occasional unsynchronized reload
        begin_test("divide");
        repeat (DIV_CYCLES) begin
            nxt_en_sync_in = (rand_below(16) != 0);
            if (rand_below(24) == 0) begin
                nxt_init = NDIV'(rand_below(1 << NDIV));
            end
            nxt_vin_code = NIN'($random(seed));
            run_cycle();
        end
        end_test();

        begin_test("alws_on");
        nxt_alws_on    = 1'b1;
        nxt_en_sync_in = 1'b1;
        repeat (ALWS_CYCLES) begin
            nxt_en_slice = (rand_below(20) != 0);
            nxt_init     = NDIV'(rand_below(1 << NDIV));
            run_cycle();
        end
        if (low_cycles == 0) begin
            $display("alws_on phase never held clk_adder low");
            test_errors++;
        end
        end_test();

        // extreme codes mixed into random ones
        begin_test("quant");
        nxt_alws_on  = 1'b0;
        nxt_en_slice = 1'b1;
        nxt_init     = '0;
        repeat (QUANT_CYCLES) begin
            case (rand_below(8))
                0: nxt_vin_code = {1'b1, {(NIN - 1){1'b0}}};
                1: nxt_vin_code = {1'b0, {(NIN - 1){1'b1}}};
                2: nxt_vin_code = '1;
                default: nxt_vin_code = NIN'($random(seed));
            endcase
            run_cycle();
        end
        end_test();

        $display("tests run %0d, tests with errors %0d, total errors %0d",
                 tests_run, tests_failed, total_errors);
        if (tests_failed == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: adc_slice.f
+incdir+include
rtl/adc_slice_pkg.sv
rtl/slice_sync_fsm.sv
rtl/phase_counter.sv
rtl/sign_mag_quantizer.sv
rtl/adc_slice_top.sv
bench/adc_slice_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the adc slice testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f adc_slice.f \
    --top-module adc_slice_tb -o adc_slice_sim || exit 1
./obj_dir/adc_slice_sim > sim.log 2>&1
cat sim.log
grep -qx "test passed" sim.log && echo "simulation ok" && exit 0
echo "simulation reported errors" && exit 1
